/* Bender.yml */
package:
  name: apu_pulse

sources:
  - hdl/apu_pkg.sv
  - hdl/pulse_reg_if.sv
  - hdl/apu_reg_decode.sv
  - hdl/pulse_chan.sv
  - hdl/frame_seq.sv
  - hdl/pulse_mixer.sv
  - hdl/apu_pulse_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/tb_apu.sv

/* filelist.f */
hdl/apu_pkg.sv
hdl/pulse_reg_if.sv
hdl/apu_reg_decode.sv
hdl/pulse_chan.sv
hdl/frame_seq.sv
hdl/pulse_mixer.sv
hdl/apu_pulse_top.sv
sim/tb_clock.sv
sim/tb_apu.sv

/* hdl/apu_pkg.sv */
// ----------------------------------------------------------------------
// Shared APU types, register map, frame step counts and lookup tables
// ----------------------------------------------------------------------
package apu_pkg;

  localparam int PERIOD_W = 11;                // Pulse timer period

  typedef logic [4:0]  apu_addr_t;
  typedef logic [7:0]  apu_data_t;
  typedef logic [3:0]  pulse_sample_t;
  typedef logic [15:0] mix_sample_t;
  typedef logic [15:0] frame_count_t;

  // ----------------------------------------------------------------------
  // Register map
  // ----------------------------------------------------------------------
  localparam apu_addr_t ADDR_SQ1_BASE = 5'h00;
  localparam apu_addr_t ADDR_SQ2_BASE = 5'h04;
  localparam apu_addr_t ADDR_STATUS   = 5'h15;  // Enable write, status read
  localparam apu_addr_t ADDR_FRAME    = 5'h17;

  // Frame sequencer step counts
  localparam frame_count_t FRAME_STEP1       = 16'd7457;
  localparam frame_count_t FRAME_STEP2       = 16'd14913;
  localparam frame_count_t FRAME_STEP3       = 16'd22371;
  localparam frame_count_t FRAME_STEP4       = 16'd29829;
  localparam frame_count_t FRAME_STEP5       = 16'd37281;
  localparam frame_count_t FRAME_RESET_COUNT = 16'd4;

  localparam logic [PERIOD_W-1:0] MIN_PERIOD = 11'd8;  // Shorter periods are silent

  // Length counter load values, indexed by data bits 7:3
  localparam apu_data_t LEN_TABLE [0:31] = '{
    8'd10,  8'd254, 8'd20,  8'd2,   8'd40,  8'd4,   8'd80,  8'd6,
    8'd160, 8'd8,   8'd60,  8'd10,  8'd14,  8'd12,  8'd26,  8'd14,
    8'd12,  8'd16,  8'd24,  8'd18,  8'd48,  8'd20,  8'd96,  8'd22,
    8'd192, 8'd24,  8'd72,  8'd26,  8'd16,  8'd28,  8'd32,  8'd30
  };

  // Nonlinear pulse mix, indexed by the sum of both pulse levels
  localparam mix_sample_t PULSE_MIX_TABLE [0:30] = '{
    16'd0,     16'd760,   16'd1503,  16'd2228,  16'd2936,  16'd3627,
    16'd4303,  16'd4963,  16'd5609,  16'd6240,  16'd6858,  16'd7462,
    16'd8053,  16'd8631,  16'd9198,  16'd9752,  16'd10296, 16'd10828,
    16'd11349, 16'd11860, 16'd12361, 16'd12852, 16'd13334, 16'd13807,
    16'd14270, 16'd14725, 16'd15171, 16'd15609, 16'd16039, 16'd16461,
    16'd16876
  };

endpackage

/* hdl/apu_pulse_top.sv */
// ----------------------------------------------------------------------
// Pulse-only APU top: decode, two pulse channels, frame sequencer, mixer
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module apu_pulse_top (
  input  logic                 clk,
  input  logic                 ce,
  input  logic                 reset,
  input  apu_pkg::apu_addr_t   address,
  input  apu_pkg::apu_data_t   data_in,
  output apu_pkg::apu_data_t   data_out,
  input  logic                 write_to_apu,
  input  logic                 read_from_apu,
  input  logic [1:0]           audio_channels,
  output apu_pkg::mix_sample_t audio_sample,
  output logic                 odd_or_even,
  output logic                 irq
);
  import apu_pkg::*;

  localparam int NUM_PULSE = 2;

  logic [NUM_PULSE-1:0] chan_enable;
  logic [NUM_PULSE-1:0] length_active;
  pulse_sample_t        samples [NUM_PULSE];
  logic                 frame_write;
  logic                 frame_mode;
  logic                 irq_inhibit;
  logic                 status_read_addr;
  logic                 status_read;
  logic                 quarter_clk;
  logic                 half_clk;
  logic                 frame_irq;

  pulse_reg_if sq_bus [NUM_PULSE] ();

  apu_reg_decode #(.NUM_PULSE(NUM_PULSE)) u_decode (
    .clk, .ce, .reset, .address, .data_in, .write_to_apu,
    .sq_bus           (sq_bus),
    .chan_enable      (chan_enable),
    .frame_write      (frame_write),
    .frame_mode       (frame_mode),
    .irq_inhibit      (irq_inhibit),
    .status_read_addr (status_read_addr)
  );

  // Channel 2 uses two's complement sweep negation
  for (genvar i = 0; i < NUM_PULSE; i++) begin : g_pulse
    pulse_chan #(.NEGATE_CARRY(i != 0)) u_pulse (
      .clk, .ce, .reset,
      .regs          (sq_bus[i]),
      .quarter_clk   (quarter_clk),
      .half_clk      (half_clk),
      .enabled       (chan_enable[i]),
      .sample        (samples[i]),
      .length_active (length_active[i])
    );
  end

  assign status_read = read_from_apu && status_read_addr;

  frame_seq u_frame (
    .clk, .ce, .reset, .frame_write, .frame_mode, .irq_inhibit,
    .status_read, .quarter_clk, .half_clk, .odd_or_even, .frame_irq
  );

  pulse_mixer #(.NUM_PULSE(NUM_PULSE)) u_mixer (
    .clk, .ce, .reset, .samples, .audio_channels, .audio_sample
  );

  assign data_out = {1'b0, frame_irq, 4'b0000, length_active};   // Status byte
  assign irq      = frame_irq;

endmodule

/* hdl/apu_reg_decode.sv */
// ----------------------------------------------------------------------
// Register write decode, channel enable register, length table lookup
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module apu_reg_decode #(
  parameter int NUM_PULSE = 2
) (
  input  logic                clk,
  input  logic                ce,
  input  logic                reset,
  input  apu_pkg::apu_addr_t  address,
  input  apu_pkg::apu_data_t  data_in,
  input  logic                write_to_apu,
  pulse_reg_if.decoder        sq_bus [NUM_PULSE],
  output logic [NUM_PULSE-1:0] chan_enable,
  output logic                frame_write,
  output logic                frame_mode,
  output logic                irq_inhibit,
  output logic                status_read_addr
);
  import apu_pkg::*;

  localparam int GROUP_STRIDE = int'(ADDR_SQ2_BASE) - int'(ADDR_SQ1_BASE);

  logic [NUM_PULSE-1:0] sq_write;
  apu_data_t            len_value;

  assign len_value = LEN_TABLE[data_in[7:3]];

  // Steer writes to the addressed pulse group
  for (genvar i = 0; i < NUM_PULSE; i++) begin : g_sq
    localparam apu_addr_t BASE = apu_addr_t'(int'(ADDR_SQ1_BASE) + i * GROUP_STRIDE);

    assign sq_write[i]         = write_to_apu && (address[4:2] == BASE[4:2]);
    assign sq_bus[i].write     = sq_write[i];
    assign sq_bus[i].address   = address[1:0];
    assign sq_bus[i].data      = data_in;
    assign sq_bus[i].len_load  = len_value;
  end

  // Frame register fields go straight to the sequencer
  assign frame_write      = write_to_apu && (address == ADDR_FRAME);
  assign frame_mode       = data_in[7];   // 1 selects the 5-step sequence
  assign irq_inhibit      = data_in[6];
  assign status_read_addr = (address == ADDR_STATUS);

  always_ff @(posedge clk) begin
    if (reset) begin
      chan_enable <= '0;
    end else if (ce) begin
      if (write_to_apu && address == ADDR_STATUS)
        chan_enable <= data_in[NUM_PULSE-1:0];
    end
  end

  // Groups do not overlap, so a write reaches at most one channel
  assert property (@(posedge clk) disable iff (reset) $onehot0(sq_write))
    else $error("more than one pulse channel strobed");

endmodule

/* hdl/frame_seq.sv */
// ----------------------------------------------------------------------
// Frame sequencer: frame clocks, even/odd flag, frame interrupt
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module frame_seq (
  input  logic clk,
  input  logic ce,
  input  logic reset,
  input  logic frame_write,
  input  logic frame_mode,
  input  logic irq_inhibit,
  input  logic status_read,
  output logic quarter_clk,
  output logic half_clk,
  output logic odd_or_even,
  output logic frame_irq
);
  import apu_pkg::*;

  frame_count_t cnt;
  logic         mode_q;          // 0 = 4-step, 1 = 5-step
  logic         inhibit_q;
  logic         write_pending;   // Frame write landed on an odd cycle

  logic step_q;
  logic step_h;
  logic at_wrap;
  logic apply_write;
  logic apply_mode;
  logic set_irq;
  logic clr_irq;

  // ----------------------------------------------------------------------
  // Step decode
  // ----------------------------------------------------------------------
  always_comb begin
    step_q  = 1'b0;
    step_h  = 1'b0;
    at_wrap = 1'b0;
    if (cnt == FRAME_STEP1 || cnt == FRAME_STEP3) begin
      step_q = 1'b1;
    end else if (cnt == FRAME_STEP2) begin
      step_q = 1'b1;
      step_h = 1'b1;
    end else if (cnt == FRAME_STEP4 && !mode_q) begin
      step_q  = 1'b1;
      step_h  = 1'b1;
      at_wrap = 1'b1;
    end else if (cnt == FRAME_STEP5) begin
      step_q  = 1'b1;
      step_h  = 1'b1;
      at_wrap = 1'b1;
    end
  end

  // Even cycle writes act now, odd ones one cycle later
  assign apply_write = (frame_write && !odd_or_even) || write_pending;
  assign apply_mode  = (frame_write && !odd_or_even) ? frame_mode : mode_q;

  assign set_irq = (cnt == FRAME_STEP4) && !mode_q && !inhibit_q;
  assign clr_irq = status_read || (frame_write && irq_inhibit);

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt           <= FRAME_RESET_COUNT;
      mode_q        <= 1'b0;
      inhibit_q     <= 1'b0;
      write_pending <= 1'b0;
      quarter_clk   <= 1'b0;
      half_clk      <= 1'b0;
      odd_or_even   <= 1'b0;
      frame_irq     <= 1'b0;
    end else if (ce) begin
      odd_or_even   <= ~odd_or_even;
      cnt           <= at_wrap ? '0 : cnt + 16'd1;
      quarter_clk   <= step_q;
      half_clk      <= step_h;
      write_pending <= frame_write && odd_or_even;

      if (frame_write) begin
        mode_q    <= frame_mode;
        inhibit_q <= irq_inhibit;
      end

      if (apply_write) begin
        cnt <= '0;
        if (apply_mode) begin   // 5-step mode clocks everything at once
          quarter_clk <= 1'b1;
          half_clk    <= 1'b1;
        end
      end

      if (set_irq)
        frame_irq <= 1'b1;      // Setting wins over a same-cycle read
      else if (clr_irq)
        frame_irq <= 1'b0;
    end
  end

  assert property (@(posedge clk) disable iff (reset) half_clk |-> quarter_clk)
    else $error("half frame clock without quarter frame clock");

endmodule

/* hdl/pulse_chan.sv */
// ----------------------------------------------------------------------
// Pulse channel: period timer, duty sequencer, envelope, sweep, length
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module pulse_chan #(
  parameter bit NEGATE_CARRY = 1'b0   // Second channel adds one on negate
) (
  input  logic                    clk,
  input  logic                    ce,
  input  logic                    reset,
  pulse_reg_if.channel            regs,
  input  logic                    quarter_clk,
  input  logic                    half_clk,
  input  logic                    enabled,
  output apu_pkg::pulse_sample_t  sample,
  output logic                    length_active
);
  import apu_pkg::*;

  // Register fields
  logic [1:0]          duty;
  logic                env_loop;       // Also halts the length counter
  logic                const_vol;
  logic [3:0]          volume;
  logic                sweep_enable;
  logic [2:0]          sweep_period;
  logic                sweep_negate;
  logic [2:0]          sweep_shift;
  logic [PERIOD_W-1:0] period;

  // Running state
  logic [PERIOD_W:0]   timer_ctr;
  logic [2:0]          seq_pos;
  logic [7:0]          len_ctr;
  logic [3:0]          envelope;
  logic [3:0]          env_divider;
  logic                env_start;
  logic [2:0]          sweep_divider;
  logic                sweep_reload;

  // ----------------------------------------------------------------------
  // Sweep target and muting
  // ----------------------------------------------------------------------
  logic [PERIOD_W-1:0] shifted;
  logic [PERIOD_W-1:0] sweep_rhs;
  logic [PERIOD_W:0]   sweep_target;
  logic                valid_freq;
  logic                duty_on;

  assign shifted      = period >> sweep_shift;
  assign sweep_rhs    = sweep_negate ? (~shifted + PERIOD_W'(NEGATE_CARRY)) : shifted;
  assign sweep_target = {1'b0, period} + {1'b0, sweep_rhs};
  assign valid_freq   = (period >= MIN_PERIOD) && (sweep_negate || !sweep_target[PERIOD_W]);

  assign length_active = (len_ctr != 8'd0);

  always_ff @(posedge clk) begin
    if (reset) begin
      duty          <= '0;
      env_loop      <= 1'b0;
      const_vol     <= 1'b0;
      volume        <= '0;
      sweep_enable  <= 1'b0;
      sweep_period  <= '0;
      sweep_negate  <= 1'b0;
      sweep_shift   <= '0;
      period        <= '0;
      timer_ctr     <= '0;
      seq_pos       <= '0;
      len_ctr       <= '0;
      envelope      <= '0;
      env_divider   <= '0;
      env_start     <= 1'b0;
      sweep_divider <= '0;
      sweep_reload  <= 1'b0;
    end else if (ce) begin
      // Timer steps the sequencer backwards every two periods
      if (timer_ctr == '0) begin
        timer_ctr <= {period, 1'b0};
        seq_pos   <= seq_pos - 3'd1;
      end else begin
        timer_ctr <= timer_ctr - 1'b1;
      end

      if (regs.write) begin
        case (regs.address)
          2'd0: begin
            duty      <= regs.data[7:6];
            env_loop  <= regs.data[5];
            const_vol <= regs.data[4];
            volume    <= regs.data[3:0];
          end
          2'd1: begin
            sweep_enable <= regs.data[7];
            sweep_period <= regs.data[6:4];
            sweep_negate <= regs.data[3];
            sweep_shift  <= regs.data[2:0];
            sweep_reload <= 1'b1;
          end
          2'd2: period[7:0] <= regs.data;
          default: begin
            period[PERIOD_W-1:8] <= regs.data[2:0];
            len_ctr              <= regs.len_load;
            env_start            <= 1'b1;
            seq_pos              <= '0;   // Restart the duty cycle
          end
        endcase
      end

      if (half_clk) begin
        if (length_active && !env_loop)
          len_ctr <= len_ctr - 8'd1;
        if (sweep_reload || sweep_divider == '0)
          sweep_divider <= sweep_period;
        else
          sweep_divider <= sweep_divider - 3'd1;
        if (sweep_divider == '0 && sweep_enable && sweep_shift != '0 && valid_freq)
          period <= sweep_target[PERIOD_W-1:0];
        sweep_reload <= 1'b0;
      end

      if (quarter_clk) begin
        if (env_start) begin
          envelope    <= 4'd15;
          env_divider <= volume;
          env_start   <= 1'b0;
        end else if (env_divider == '0) begin
          env_divider <= volume;
          if (envelope != '0 || env_loop)
            envelope <= envelope - 4'd1;   // Wraps to 15 when looping
        end else begin
          env_divider <= env_divider - 4'd1;
        end
      end

      if (!enabled)
        len_ctr <= '0;
    end
  end

  always_comb begin
    case (duty)
      2'd0:    duty_on = (seq_pos == 3'd7);
      2'd1:    duty_on = (seq_pos >= 3'd6);
      2'd2:    duty_on = (seq_pos >= 3'd4);
      default: duty_on = (seq_pos < 3'd6);    // Inverted 25%
    endcase
    if (!length_active || !valid_freq || !duty_on)
      sample = '0;
    else
      sample = const_vol ? volume : envelope;
  end

  assert property (@(posedge clk) disable iff (reset) (sample != '0) |-> length_active)
    else $error("pulse sounds with an empty length counter");

endmodule

/* hdl/pulse_mixer.sv */
// ----------------------------------------------------------------------
// Pulse channel muting and registered nonlinear mix lookup
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module pulse_mixer #(
  parameter int NUM_PULSE = 2
) (
  input  logic                   clk,
  input  logic                   ce,
  input  logic                   reset,
  input  apu_pkg::pulse_sample_t samples [NUM_PULSE],
  input  logic [NUM_PULSE-1:0]   audio_channels,   // 1 lets a channel through
  output apu_pkg::mix_sample_t   audio_sample
);
  import apu_pkg::*;

  logic [4:0] mix_index;

  // Sum of the unmuted levels, at most 30
  always_comb begin
    mix_index = '0;
    for (int i = 0; i < NUM_PULSE; i++) begin
      if (audio_channels[i])
        mix_index = mix_index + 5'(samples[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      audio_sample <= '0;
    end else if (ce) begin
      audio_sample <= PULSE_MIX_TABLE[mix_index];
    end
  end

endmodule

/* hdl/pulse_reg_if.sv */
// ----------------------------------------------------------------------
// Register write path from the decoder to one pulse channel
// ----------------------------------------------------------------------
`timescale 1ns/100ps

interface pulse_reg_if;
  import apu_pkg::*;

  logic       write;     // One cycle strobe, qualified by ce
  logic [1:0] address;   // Register index within the group
  apu_data_t  data;
  apu_data_t  len_load;  // Length value already looked up

  modport decoder (
    output write,
    output address,
    output data,
    output len_load
  );

  modport channel (
    input write,
    input address,
    input data,
    input len_load
  );

endinterface

/* sim/tb_apu.sv */
// ----------------------------------------------------------------------
// Testbench for the pulse-only APU: random stimulus, model and checks
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module tb_apu;
  import apu_pkg::*;

  logic        clk;
  logic        ce;
  logic        reset;
  apu_addr_t   address;
  apu_data_t   data_in;
  apu_data_t   data_out;
  logic        write_to_apu;
  logic        read_from_apu;
  logic [1:0]  audio_channels;
  mix_sample_t audio_sample;
  logic        odd_or_even;
  logic        irq;

  logic [31:0] rng;
  int          cyc;         // Rising edges since time zero
  int          e0;          // Edge at which the frame counter last cleared
  logic [1:0]  en_model;
  logic [1:0]  act_model;   // Expected length activity per channel

  tb_clock #(.PERIOD_NS(40)) u_clock (.clk);

  apu_pulse_top uut (
    .clk, .ce, .reset, .address, .data_in, .data_out, .write_to_apu,
    .read_from_apu, .audio_channels, .audio_sample, .odd_or_even, .irq
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic apu_addr_t sq_addr(input int ch, input int offset);
    return (ch == 0 ? ADDR_SQ1_BASE : ADDR_SQ2_BASE) + apu_addr_t'(offset);
  endfunction

  // Edge at which the len-th half frame clock reaches the length counter (4-step)
  function automatic int length_drop_edge(input int start, input int len);
    int base;
    int drop_at;
    base    = start;
    drop_at = 0;
    for (int n = 1; n <= len; n++) begin
      if (n % 2 == 1) begin
        drop_at = base + int'(FRAME_STEP2) + 2;
      end else begin
        drop_at = base + int'(FRAME_STEP4) + 2;
        base    = base + int'(FRAME_STEP4) + 1;   // Counter wraps after step 4
      end
    end
    return drop_at;
  endfunction

  task automatic report_error(input string msg);
    $display("ERR %0t ns: %s", $time, msg);
    $display(">>> FAIL");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t ns while waiting for %s", $time, what);
    $display(">>> FAIL");
    $fatal(1, "stopped on timeout");
  endtask

  task automatic tick();
    @(posedge clk);
    cyc = cyc + 1;
    #2;
    // Flag toggles every cycle once reset is released after edge 4
    assert (odd_or_even == (cyc > 4 && (cyc - 4) % 2 == 1))
      else report_error($sformatf("odd_or_even %b at edge %0d", odd_or_even, cyc));
  endtask

  task automatic write_reg(input apu_addr_t a, input apu_data_t d);
    address      = a;
    data_in      = d;
    write_to_apu = 1'b1;
    tick();
    write_to_apu = 1'b0;
  endtask

  // Frame writes go out on an even cycle so the counter clears at once
  task automatic write_frame(input apu_data_t d);
    int guard;
    guard = 0;
    while (odd_or_even) begin
      tick();
      guard++;
      if (guard > 4)
        report_timeout("an even cycle");
    end
    e0 = cyc + 1;
    write_reg(ADDR_FRAME, d);
  endtask

  task automatic expect_silence(input int n, input string why);
    repeat (n) begin
      tick();
      assert (audio_sample == PULSE_MIX_TABLE[0])
        else report_error($sformatf("audio %0d while %s", audio_sample, why));
    end
  endtask

  initial begin
    int          ch;
    int          idx;
    int          drop_at;
    int          irq_at;
    logic [3:0]  vol;
    logic [1:0]  duty;
    logic [7:0]  per;
    bit          seen_low;
    bit          seen_high;

    rng            = 32'h9304_f083;
    cyc            = 0;
    e0             = 0;
    ce             = 1'b1;
    reset          = 1'b1;
    address        = '0;
    data_in        = '0;
    write_to_apu   = 1'b0;
    read_from_apu  = 1'b0;
    audio_channels = 2'b11;
    en_model       = '0;
    act_model      = '0;
    repeat (4) tick();
    reset = 1'b0;

    assert (data_out == '0 && irq == 1'b0 && audio_sample == '0)
      else report_error("outputs not idle after reset");

    // ------------------------------------------------------------------
    // Enable register and length loads, halted counters
    // ------------------------------------------------------------------
    write_reg(sq_addr(0, 0), 8'h20);
    write_reg(sq_addr(1, 0), 8'h20);
    repeat (40) begin
      rng = xorshift32(rng);
      if (rng[0]) begin
        write_reg(ADDR_STATUS, {6'b0, rng[9:8]});
        en_model  = rng[9:8];
        act_model = act_model & en_model;
      end else begin
        ch = int'(rng[1]);
        write_reg(sq_addr(ch, 3), {rng[7:3], 3'b000});
        act_model[ch] = en_model[ch];     // Disabled channel ignores the load
      end
      tick();
      // No frame interrupt yet this early, so only the length bits may be set
      assert (data_out == {6'b000000, act_model})
        else report_error($sformatf("status %b, model %b", data_out,
                                    {6'b000000, act_model}));
    end

    // ------------------------------------------------------------------
    // Length expiry and frame interrupt in 4-step mode
    // ------------------------------------------------------------------
    rng = xorshift32(rng);
    ch  = int'(rng[0]);
    idx = 3 + 2 * (int'(rng[9:8]) % 3);
    write_reg(ADDR_STATUS, 8'h03);
    write_frame(8'h00);
    write_reg(sq_addr(ch, 0), 8'h00);          // Halt clear
    write_reg(sq_addr(ch, 3), 8'(idx << 3));
    drop_at = length_drop_edge(e0, int'(LEN_TABLE[idx]));
    irq_at  = e0 + int'(FRAME_STEP4) + 1;
    while (cyc < drop_at + 2) begin
      tick();
      assert (data_out[ch] == (cyc < drop_at))
        else report_error($sformatf("channel %0d status %b, drop due at edge %0d",
                                    ch, data_out[ch], drop_at));
      assert (irq == (cyc >= irq_at))
        else report_error($sformatf("irq %b, rise due at edge %0d", irq, irq_at));
    end

    address       = ADDR_STATUS;
    read_from_apu = 1'b1;
    #1;
    assert (data_out[6]) else report_error("status read shows no frame interrupt");
    tick();
    read_from_apu = 1'b0;
    assert (!irq) else report_error("irq still set after status read");

    // Inhibited, then 5-step mode
    for (int k = 0; k < 2; k++) begin
      write_frame(k == 0 ? 8'h40 : 8'h80);
      repeat (int'(FRAME_STEP5) + 8) begin
        tick();
        assert (!irq) else report_error("irq set with no frame interrupt expected");
      end
    end

    // ------------------------------------------------------------------
    // Constant volume pulse through the mixer
    // ------------------------------------------------------------------
    rng  = xorshift32(rng);
    ch   = int'(rng[0]);
    vol  = 4'(1 + int'(rng[7:4]) % 15);
    duty = rng[9:8];
    per  = 8'(int'(MIN_PERIOD) + int'(rng[21:16]) % 64);
    audio_channels = 2'b01 << ch;
    write_reg(ADDR_STATUS, 8'h03);
    write_reg(sq_addr(ch, 0), {duty, 2'b11, vol});   // Halt, constant volume
    write_reg(sq_addr(ch, 1), 8'h00);                // Sweep off
    write_reg(sq_addr(ch, 2), per);
    write_reg(sq_addr(ch, 3), 8'h08);                // Long length, period high 0
    tick();
    seen_low  = 1'b0;
    seen_high = 1'b0;
    repeat (48 * (int'(per) + 1)) begin
      tick();
      assert (audio_sample == PULSE_MIX_TABLE[0] || audio_sample == PULSE_MIX_TABLE[vol])
        else report_error($sformatf("audio %0d, volume %0d", audio_sample, vol));
      if (audio_sample == PULSE_MIX_TABLE[vol])
        seen_high = 1'b1;
      else
        seen_low = 1'b1;
    end
    assert (seen_low && seen_high)
      else report_error($sformatf("pulse never toggled, duty %0d period %0d", duty, per));

    audio_channels = 2'b00;
    expect_silence(400, "channel muted");

    audio_channels = 2'b01 << ch;
    rng = xorshift32(rng);
    write_reg(sq_addr(ch, 2), {5'b0, rng[2:0]});
    tick();
    expect_silence(400, "period below minimum");

    $display(">>> PASS");
    $finish;
  end

endmodule

/* sim/tb_clock.sv */
// ----------------------------------------------------------------------
// Free running testbench clock
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module tb_clock #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule
